// ==== flist.f ====
verilog/ros2_ether_pkg.sv
verilog/byte_queue.sv
verilog/app_data_arbiter.sv
verilog/buffer_owner.sv
verilog/ros2_ether_shell.sv
testbench/tb_ros2_ether_shell.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the ros2_ether_shell testbench with Verilator and runs it.
# The run counts as failed when the log holds the fail message.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_ros2_ether_shell
BUILD_DIR=obj_dir
SIM_BIN=sim_top
LOG=sim.log

verilator --binary --timing \
  -f flist.f \
  --top-module "$TOP" \
  --Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q '>>> FAIL' "$LOG"; then
  exit 1
fi

if ! grep -q '>>> PASS' "$LOG"; then
  echo "simulation log holds no result line"
  exit 1
fi

exit 0

// ==== testbench/tb_testdata.txt ====
# command a b c d expected, all hex. app: a,b,c,d = engine req/rel, cpu req/rel.
# queue commands: a = 0 outgoing or 1 incoming, b = byte; see the testbench tasks.
reset 0 0 0 0 095
# application data arbiter, expected {engine_grant, cpu_grant}
app 1 0 1 0 2
app 0 0 1 0 2
app 0 0 0 1 2
app 0 1 1 0 0
app 0 0 1 0 1
app 1 0 0 0 1
app 1 0 0 1 0
app 1 0 0 0 2
# buffer handoff, a = engine release, b = cpu release
rxbuf 0 1 0 0 2
rxbuf 1 0 0 0 1
rxbuf 1 0 0 0 1
rxbuf 0 1 0 0 2
rxbuf 1 1 0 0 1
rxbuf 0 0 0 0 1
txbuf 1 0 0 0 1
txbuf 0 1 0 0 2
txbuf 1 1 0 0 1
txbuf 0 1 0 0 2
# enable gating, expected six grants
enable 0 0 0 0 00
rxbuf 0 0 0 0 0
enable 1 0 0 0 26
# fill, overflow and drain
push 0 a5 0 0 0
push 0 3c 0 0 0
push 0 e1 0 0 0
fill 0 0 0 0 10
drop 0 77 0 0 1
drain 0 0 0 0 10
push 1 5a 0 0 0
push 1 c3 0 0 0
fill 1 0 0 0 10
drop 1 88 0 0 1
drain 1 0 0 0 10
# read and write in the same cycle, expected head byte
push 0 11 0 0 0
push 0 22 0 0 0
push 0 33 0 0 0
rdwr 0 44 0 0 11
rdwr 0 55 0 0 22
rdwr 0 66 0 0 33
drain 0 0 0 0 3
push 1 f0 0 0 0
rdwr 1 0f 0 0 f0
rdwr 1 1e 0 0 0f
drain 1 0 0 0 1
reset 0 0 0 0 095

// ==== testbench/tb_ros2_ether_shell.sv ====
`timescale 1ns/10ps

module tb_ros2_ether_shell;

  localparam string DATA_FILE  = "testbench/tb_testdata.txt";
  localparam int    WAIT_LIMIT = 40;   // cycles, well above either queue depth.

  logic       clk;
  logic       rst_n;
  logic       i_ether_en;
  logic       i_app_engine_req;
  logic       i_app_engine_rel;
  logic       i_app_cpu_req;
  logic       i_app_cpu_rel;
  logic       o_app_engine_grant;
  logic       o_app_cpu_grant;
  logic       i_rxbuf_engine_rel;
  logic       i_rxbuf_cpu_rel;
  logic       o_rxbuf_engine_grant;
  logic       o_rxbuf_cpu_grant;
  logic       i_txbuf_engine_rel;
  logic       i_txbuf_cpu_rel;
  logic       o_txbuf_engine_grant;
  logic       o_txbuf_cpu_grant;
  logic       i_tx_wr_en;
  logic [7:0] i_tx_din;
  logic       o_tx_full;
  logic       i_tx_rd_en;
  logic [7:0] o_tx_dout;
  logic       o_tx_empty;
  logic       i_rx_wr_en;
  logic [7:0] i_rx_din;
  logic       o_rx_full;
  logic       i_rx_rd_en;
  logic [7:0] o_rx_dout;
  logic       o_rx_empty;

  int          checks;
  int          value_errors;
  int          other_errors;
  bit          timed_out;
  logic [31:0] lfsr_state;
  logic [7:0]  tx_model[$];   // bytes the outgoing queue should hold, oldest first.
  logic [7:0]  rx_model[$];

  ros2_ether_shell i_dut (
    .clk (clk), .rst_n (rst_n), .i_ether_en (i_ether_en),
    .i_app_engine_req (i_app_engine_req), .i_app_engine_rel (i_app_engine_rel),
    .i_app_cpu_req (i_app_cpu_req), .i_app_cpu_rel (i_app_cpu_rel),
    .o_app_engine_grant (o_app_engine_grant), .o_app_cpu_grant (o_app_cpu_grant),
    .i_rxbuf_engine_rel (i_rxbuf_engine_rel), .i_rxbuf_cpu_rel (i_rxbuf_cpu_rel),
    .o_rxbuf_engine_grant (o_rxbuf_engine_grant), .o_rxbuf_cpu_grant (o_rxbuf_cpu_grant),
    .i_txbuf_engine_rel (i_txbuf_engine_rel), .i_txbuf_cpu_rel (i_txbuf_cpu_rel),
    .o_txbuf_engine_grant (o_txbuf_engine_grant), .o_txbuf_cpu_grant (o_txbuf_cpu_grant),
    .i_tx_wr_en (i_tx_wr_en), .i_tx_din (i_tx_din), .o_tx_full (o_tx_full),
    .i_tx_rd_en (i_tx_rd_en), .o_tx_dout (o_tx_dout), .o_tx_empty (o_tx_empty),
    .i_rx_wr_en (i_rx_wr_en), .i_rx_din (i_rx_din), .o_rx_full (o_rx_full),
    .i_rx_rd_en (i_rx_rd_en), .o_rx_dout (o_rx_dout), .o_rx_empty (o_rx_empty)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period.
  end

  // **********************************************************************
  // Output views and the reference queues
  // **********************************************************************

  function automatic logic [31:0] pair_word(input logic eng, input logic cpu);
    return {30'd0, eng, cpu};
  endfunction

  function automatic logic [31:0] grant_word();
    return {26'd0, o_app_engine_grant, o_app_cpu_grant, o_rxbuf_engine_grant,
            o_rxbuf_cpu_grant, o_txbuf_engine_grant, o_txbuf_cpu_grant};
  endfunction

  function automatic logic [31:0] status_word();
    return {22'd0, o_app_engine_grant, o_app_cpu_grant, o_rxbuf_engine_grant,
            o_rxbuf_cpu_grant, o_txbuf_engine_grant, o_txbuf_cpu_grant,
            o_tx_full, o_tx_empty, o_rx_full, o_rx_empty};
  endfunction

  // queue select is 0 for the outgoing queue and 1 for the incoming one.
  function automatic logic queue_full(input logic q);
    return q ? o_rx_full : o_tx_full;
  endfunction

  function automatic logic queue_empty(input logic q);
    return q ? o_rx_empty : o_tx_empty;
  endfunction

  function automatic logic [7:0] queue_dout(input logic q);
    return q ? o_rx_dout : o_tx_dout;
  endfunction

  function automatic logic [31:0] model_size(input logic q);
    return q ? 32'(rx_model.size()) : 32'(tx_model.size());
  endfunction

  task automatic model_push(input logic q, input logic [7:0] b);
    if (q) rx_model.push_back(b);
    else tx_model.push_back(b);
  endtask

  task automatic model_pop(input logic q, output logic [7:0] b);
    if (q) b = rx_model.pop_front();
    else b = tx_model.pop_front();
  endtask

  // taps 32, 22, 2 and 1 give a maximal length sequence.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_byte(output logic [7:0] b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    value_errors++;
    $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("%s", what);
  endtask

  task automatic drive_queue(input logic q, input logic wr, input logic [7:0] din,
                             input logic rd);
    if (q) begin
      i_rx_wr_en = wr;
      i_rx_din   = din;
      i_rx_rd_en = rd;
    end else begin
      i_tx_wr_en = wr;
      i_tx_din   = din;
      i_tx_rd_en = rd;
    end
  endtask

  // **********************************************************************
  // Commands, each starts and ends on a falling edge
  // **********************************************************************

  task automatic apply_reset(input logic [31:0] exp, input string name);
    rst_n = 1'b0;
    tx_model.delete();
    rx_model.delete();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    checks++;
    if (status_word() !== exp) report_mismatch(name, exp, status_word());
  endtask

  task automatic pulse_app(input logic [31:0] a, b, c, d, exp, input string name);
    i_app_engine_req = a[0];
    i_app_engine_rel = b[0];
    i_app_cpu_req    = c[0];
    i_app_cpu_rel    = d[0];
    @(negedge clk);   // grant shows one cycle after the sampling edge.
    checks++;
    if (pair_word(o_app_engine_grant, o_app_cpu_grant) !== exp) begin
      report_mismatch(name, exp, pair_word(o_app_engine_grant, o_app_cpu_grant));
    end
    i_app_engine_req = 1'b0;
    i_app_engine_rel = 1'b0;
    i_app_cpu_req    = 1'b0;
    i_app_cpu_rel    = 1'b0;
  endtask

  task automatic pulse_buffer(input logic tx_sel, input logic [31:0] a, b, exp,
                              input string name);
    logic [31:0] act;
    i_rxbuf_engine_rel = ~tx_sel & a[0];
    i_rxbuf_cpu_rel    = ~tx_sel & b[0];
    i_txbuf_engine_rel = tx_sel & a[0];
    i_txbuf_cpu_rel    = tx_sel & b[0];
    @(negedge clk);
    act = tx_sel ? pair_word(o_txbuf_engine_grant, o_txbuf_cpu_grant)
                 : pair_word(o_rxbuf_engine_grant, o_rxbuf_cpu_grant);
    checks++;
    if (act !== exp) report_mismatch(name, exp, act);
    i_rxbuf_engine_rel = 1'b0;
    i_rxbuf_cpu_rel    = 1'b0;
    i_txbuf_engine_rel = 1'b0;
    i_txbuf_cpu_rel    = 1'b0;
  endtask

  task automatic set_enable(input logic en, input logic [31:0] exp, input string name);
    i_ether_en = en;
    @(negedge clk);
    checks++;
    if (grant_word() !== exp) report_mismatch(name, exp, grant_word());
  endtask

  // exp is the empty flag after the write, or the full flag for a dropped one.
  task automatic write_byte(input logic q, input logic [7:0] din, input logic dropped,
                            input logic [31:0] exp, input string name);
    logic [31:0] act;
    drive_queue(q, 1'b1, din, 1'b0);
    if (!dropped) model_push(q, din);
    @(negedge clk);
    drive_queue(q, 1'b0, 8'h00, 1'b0);
    act = dropped ? {31'd0, queue_full(q)} : {31'd0, queue_empty(q)};
    checks++;
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  task automatic fill_queue(input logic q, input logic [31:0] exp, input string name);
    int          writes;
    logic [7:0]  b;
    writes = 0;
    while (!queue_full(q) && writes < WAIT_LIMIT) begin
      random_byte(b);
      drive_queue(q, 1'b1, b, 1'b0);
      model_push(q, b);
      @(negedge clk);
      writes++;
    end
    drive_queue(q, 1'b0, 8'h00, 1'b0);
    if (!queue_full(q)) begin
      report_failure($sformatf("%s: the full flag never rose", name));
      timed_out = 1'b1;
    end else begin
      checks++;
      if (model_size(q) !== exp) report_mismatch(name, exp, model_size(q));
    end
  endtask

  // exp is the head byte seen as the read and the write go in together.
  task automatic read_write_byte(input logic q, input logic [7:0] din,
                                 input logic [31:0] exp, input string name);
    logic [7:0] head;
    checks++;
    if ({24'd0, queue_dout(q)} !== exp) report_mismatch(name, exp, {24'd0, queue_dout(q)});
    if (model_size(q) == 32'd0) report_failure($sformatf("%s: nothing left to read", name));
    else model_pop(q, head);
    model_push(q, din);
    drive_queue(q, 1'b1, din, 1'b1);
    @(negedge clk);
    drive_queue(q, 1'b0, 8'h00, 1'b0);
  endtask

  task automatic drain_queue(input logic q, input logic [31:0] exp, input string name);
    int         reads;
    logic [7:0] head;
    reads = 0;
    while (!queue_empty(q) && reads < WAIT_LIMIT) begin
      head = 8'h00;
      if (model_size(q) == 32'd0) begin
        report_failure($sformatf("%s: queue returned a byte that was never written", name));
      end else begin
        model_pop(q, head);
      end
      checks++;
      if (queue_dout(q) !== head) report_mismatch(name, {24'd0, head}, {24'd0, queue_dout(q)});
      drive_queue(q, 1'b0, 8'h00, 1'b1);
      @(negedge clk);
      reads++;
    end
    drive_queue(q, 1'b0, 8'h00, 1'b0);
    if (!queue_empty(q)) begin
      report_failure($sformatf("%s: the empty flag never rose", name));
      timed_out = 1'b1;
    end else begin
      checks++;
      if (32'(reads) !== exp) report_mismatch(name, exp, 32'(reads));
      if (model_size(q) != 32'd0) report_failure($sformatf("%s: bytes were lost", name));
    end
  endtask

  task automatic run_line(input string line, input int line_no);
    string       cmd;
    string       name;
    logic [31:0] a, b, c, d, exp;
    int          n;
    cmd = "";
    if (line.len() == 0 || line.getc(0) == 8'h23) return;   // 8'h23 starts a comment.
    n = $sscanf(line, "%s %h %h %h %h %h", cmd, a, b, c, d, exp);
    if (n <= 0) return;
    name = $sformatf("%s (line %0d)", cmd, line_no);
    if (n != 6) report_failure($sformatf("line %0d of the data file is malformed", line_no));
    else if (cmd == "reset") apply_reset(exp, name);
    else if (cmd == "app") pulse_app(a, b, c, d, exp, name);
    else if (cmd == "rxbuf") pulse_buffer(1'b0, a, b, exp, name);
    else if (cmd == "txbuf") pulse_buffer(1'b1, a, b, exp, name);
    else if (cmd == "enable") set_enable(a[0], exp, name);
    else if (cmd == "push") write_byte(a[0], b[7:0], 1'b0, exp, name);
    else if (cmd == "drop") write_byte(a[0], b[7:0], 1'b1, exp, name);
    else if (cmd == "fill") fill_queue(a[0], exp, name);
    else if (cmd == "rdwr") read_write_byte(a[0], b[7:0], exp, name);
    else if (cmd == "drain") drain_queue(a[0], exp, name);
    else report_failure($sformatf("unknown command %s on line %0d", cmd, line_no));
  endtask

  // **********************************************************************
  // Main sequence
  // **********************************************************************

  initial begin
    int    fd;
    int    code;
    int    line_no;
    string line;
    rst_n = 1'b0;
    i_ether_en = 1'b1;
    i_app_engine_req = 1'b0;
    i_app_engine_rel = 1'b0;
    i_app_cpu_req = 1'b0;
    i_app_cpu_rel = 1'b0;
    i_rxbuf_engine_rel = 1'b0;
    i_rxbuf_cpu_rel = 1'b0;
    i_txbuf_engine_rel = 1'b0;
    i_txbuf_cpu_rel = 1'b0;
    drive_queue(1'b0, 1'b0, 8'h00, 1'b0);
    drive_queue(1'b1, 1'b0, 8'h00, 1'b0);
    checks = 0;
    value_errors = 0;
    other_errors = 0;
    timed_out = 1'b0;
    lfsr_state = 32'hbd58_0315;
    line_no = 0;
    @(negedge clk);
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      report_failure({"could not open ", DATA_FILE});
    end else begin
      while (!$feof(fd) && !timed_out) begin
        line = "";
        code = $fgets(line, fd);
        line_no++;
        if (code > 0) run_line(line, line_no);
      end
      $fclose(fd);
    end
    if (checks == 0) report_failure("no checks were run");
    $display("checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/ros2_ether_shell.sv ====
`timescale 1ns/10ps

module ros2_ether_shell (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               i_ether_en,

  input  logic                               i_app_engine_req,
  input  logic                               i_app_engine_rel,
  input  logic                               i_app_cpu_req,
  input  logic                               i_app_cpu_rel,
  output logic                               o_app_engine_grant,
  output logic                               o_app_cpu_grant,

  input  logic                               i_rxbuf_engine_rel,
  input  logic                               i_rxbuf_cpu_rel,
  output logic                               o_rxbuf_engine_grant,
  output logic                               o_rxbuf_cpu_grant,

  input  logic                               i_txbuf_engine_rel,
  input  logic                               i_txbuf_cpu_rel,
  output logic                               o_txbuf_engine_grant,
  output logic                               o_txbuf_cpu_grant,

  input  logic                               i_tx_wr_en,
  input  logic [ros2_ether_pkg::BYTE_W-1:0]  i_tx_din,
  output logic                               o_tx_full,
  input  logic                               i_tx_rd_en,
  output logic [ros2_ether_pkg::BYTE_W-1:0]  o_tx_dout,
  output logic                               o_tx_empty,

  input  logic                               i_rx_wr_en,
  input  logic [ros2_ether_pkg::BYTE_W-1:0]  i_rx_din,
  output logic                               o_rx_full,
  input  logic                               i_rx_rd_en,
  output logic [ros2_ether_pkg::BYTE_W-1:0]  o_rx_dout,
  output logic                               o_rx_empty
);

  import ros2_ether_pkg::*;

  logic app_engine_grant;
  logic app_cpu_grant;
  logic rxbuf_engine_grant;
  logic rxbuf_cpu_grant;
  logic txbuf_engine_grant;
  logic txbuf_cpu_grant;

  // **********************************************************************
  // Byte queues
  // **********************************************************************

  byte_queue #(
    .DEPTH (TX_QUEUE_DEPTH)
  ) u_tx_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr_en (i_tx_wr_en),
    .i_din   (i_tx_din),
    .o_full  (o_tx_full),
    .i_rd_en (i_tx_rd_en),
    .o_dout  (o_tx_dout),
    .o_empty (o_tx_empty)
  );

  byte_queue #(
    .DEPTH (RX_QUEUE_DEPTH)
  ) u_rx_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr_en (i_rx_wr_en),
    .i_din   (i_rx_din),
    .o_full  (o_rx_full),
    .i_rd_en (i_rx_rd_en),
    .o_dout  (o_rx_dout),
    .o_empty (o_rx_empty)
  );

  // **********************************************************************
  // Shared region ownership
  // **********************************************************************

  app_data_arbiter u_app_arb (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_engine_req   (i_app_engine_req),
    .i_engine_rel   (i_app_engine_rel),
    .i_cpu_req      (i_app_cpu_req),
    .i_cpu_rel      (i_app_cpu_rel),
    .o_engine_grant (app_engine_grant),
    .o_cpu_grant    (app_cpu_grant)
  );

  buffer_owner #(
    .RESET_OWNER (OWNER_ENGINE)   // the engine is first to fill the rx buffer.
  ) u_rxbuf_owner (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_engine_rel   (i_rxbuf_engine_rel),
    .i_cpu_rel      (i_rxbuf_cpu_rel),
    .o_engine_grant (rxbuf_engine_grant),
    .o_cpu_grant    (rxbuf_cpu_grant)
  );

  buffer_owner #(
    .RESET_OWNER (OWNER_CPU)      // the CPU is first to fill the tx buffer.
  ) u_txbuf_owner (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_engine_rel   (i_txbuf_engine_rel),
    .i_cpu_rel      (i_txbuf_cpu_rel),
    .o_engine_grant (txbuf_engine_grant),
    .o_cpu_grant    (txbuf_cpu_grant)
  );

  // grants are masked while Ethernet is off, the owner state itself is kept.
  assign o_app_engine_grant   = i_ether_en & app_engine_grant;
  assign o_app_cpu_grant      = i_ether_en & app_cpu_grant;
  assign o_rxbuf_engine_grant = i_ether_en & rxbuf_engine_grant;
  assign o_rxbuf_cpu_grant    = i_ether_en & rxbuf_cpu_grant;
  assign o_txbuf_engine_grant = i_ether_en & txbuf_engine_grant;
  assign o_txbuf_cpu_grant    = i_ether_en & txbuf_cpu_grant;

endmodule

// ==== verilog/buffer_owner.sv ====
`timescale 1ns/10ps

module buffer_owner #(
  parameter ros2_ether_pkg::buf_owner_e RESET_OWNER = ros2_ether_pkg::OWNER_ENGINE
) (
  input  logic clk,
  input  logic rst_n,
  input  logic i_engine_rel,
  input  logic i_cpu_rel,
  output logic o_engine_grant,
  output logic o_cpu_grant
);

  import ros2_ether_pkg::*;

  buf_owner_e owner;

  // the buffer changes hands only when its current owner lets go of it.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner <= RESET_OWNER;
    end else begin
      case (owner)
        OWNER_ENGINE: begin
          if (i_engine_rel) begin
            owner <= OWNER_CPU;
          end
        end
        OWNER_CPU: begin
          if (i_cpu_rel) begin
            owner <= OWNER_ENGINE;
          end
        end
      endcase
    end
  end

  // exactly one side holds the buffer at any time.
  assign o_engine_grant = (owner == OWNER_ENGINE);
  assign o_cpu_grant    = (owner == OWNER_CPU);

endmodule

// ==== verilog/app_data_arbiter.sv ====
`timescale 1ns/10ps

module app_data_arbiter (
  input  logic clk,
  input  logic rst_n,
  input  logic i_engine_req,
  input  logic i_engine_rel,
  input  logic i_cpu_req,
  input  logic i_cpu_rel,
  output logic o_engine_grant,
  output logic o_cpu_grant
);

  import ros2_ether_pkg::*;

  app_grant_e state;

  // **********************************************************************
  // Grant FSM
  // **********************************************************************

  // a holder keeps the region until it releases it, the other side waits.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= APP_GRANT_NONE;
    end else begin
      case (state)
        APP_GRANT_NONE: begin
          if (i_engine_req) begin
            state <= APP_GRANT_ENGINE;   // engine wins a tie.
          end else if (i_cpu_req) begin
            state <= APP_GRANT_CPU;
          end
        end
        APP_GRANT_ENGINE: begin
          if (i_engine_rel) begin
            state <= APP_GRANT_NONE;
          end
        end
        APP_GRANT_CPU: begin
          if (i_cpu_rel) begin
            state <= APP_GRANT_NONE;
          end
        end
        default: begin
          state <= APP_GRANT_NONE;   // the unused encoding falls back to free.
        end
      endcase
    end
  end

  assign o_engine_grant = (state == APP_GRANT_ENGINE);
  assign o_cpu_grant    = (state == APP_GRANT_CPU);

endmodule

// ==== verilog/byte_queue.sv ====
`timescale 1ns/10ps

module byte_queue #(
  parameter int DEPTH = 16
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               i_wr_en,
  input  logic [ros2_ether_pkg::BYTE_W-1:0]  i_din,
  output logic                               o_full,
  input  logic                               i_rd_en,
  output logic [ros2_ether_pkg::BYTE_W-1:0]  o_dout,
  output logic                               o_empty
);

  import ros2_ether_pkg::*;

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] FULL_CNT = DEPTH[AW:0];

  logic [BYTE_W-1:0] mem [DEPTH];
  logic [AW-1:0]     wr_ptr;
  logic [AW-1:0]     rd_ptr;
  logic [AW:0]       count;   // one bit wider than the pointers to hold DEPTH.
  logic              wr_ok;
  logic              rd_ok;

  assign wr_ok = i_wr_en & ~o_full;   // a write into a full queue is lost.
  assign rd_ok = i_rd_en & ~o_empty;

  // storage array, written at the tail.
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= i_din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;   // wraps, DEPTH is a power of two.
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;   // idle, or a push and a pop together.
      endcase
    end
  end

  // show-ahead output, the head entry is always on o_dout.
  assign o_dout  = mem[rd_ptr];
  assign o_full  = (count == FULL_CNT);
  assign o_empty = (count == '0);

endmodule

// ==== verilog/ros2_ether_pkg.sv ====
package ros2_ether_pkg;

  // **********************************************************************
  // Byte queues
  // **********************************************************************

  localparam int BYTE_W         = 8;   // width of one queue entry.
  localparam int TX_QUEUE_DEPTH = 16;  // engine to network.
  localparam int RX_QUEUE_DEPTH = 16;  // network to engine.

  // **********************************************************************
  // Ownership of the shared regions
  // **********************************************************************

  // the application data region has a free state between two owners.
  typedef enum logic [1:0] {
    APP_GRANT_NONE   = 2'b00,
    APP_GRANT_ENGINE = 2'b01,
    APP_GRANT_CPU    = 2'b10
  } app_grant_e;

  // a UDP buffer always belongs to exactly one side.
  typedef enum logic {
    OWNER_ENGINE = 1'b0,
    OWNER_CPU    = 1'b1
  } buf_owner_e;

endpackage
